// File: verilog/fpga_io_pkg.sv
// Shared types, register map and serial timing for the board I/O block; referenced by scoped name
`default_nettype none

package fpga_io_pkg;

	// Processor-side word address and data
	typedef logic [31:0] io_addr_t;
	typedef logic [31:0] io_data_t;

	// Request from the processor I/O port
	// Strobes are one cycle wide, never both high together
	typedef struct packed {
		logic write_en;
		logic read_en;
		io_addr_t address;
		io_data_t write_data;
	} io_req_t;

	// Board LED banks
	typedef logic [17:0] red_led_t;
	typedef logic [8:0] green_led_t;

	// Display register fields
	// Digit 0 in the low nibble
	typedef logic [15:0] hex_digits_t;
	// One bit per digit, set means dark
	typedef logic [3:0] blank_mask_t;
	// Segments g..a, active low
	typedef logic [6:0] seg_t;

	// Serial payload
	typedef logic [7:0] uart_byte_t;

	// Register map, word addresses
	localparam io_addr_t IO_RED_LED = 32'h0000_0000;
	localparam io_addr_t IO_GREEN_LED = 32'h0000_0004;
	localparam io_addr_t IO_HEX_DISPLAY = 32'h0000_0008;
	// Write sends low byte, read gives status
	localparam io_addr_t IO_UART = 32'h0000_000C;

	// Status word bit for transmitter busy
	localparam int UART_STATUS_BUSY_BIT = 0;

	// Clocks per serial bit at clk50
	localparam int UART_CLOCKS_PER_BIT = 16;

endpackage

`default_nettype wire

// File: verilog/io_regs.sv
// Memory-mapped register block; decodes the processor I/O port into LED, display and UART registers
`timescale 1ns/1ps
`default_nettype none

module io_regs (
	input logic clk50,
	input logic rst_n,
	input fpga_io_pkg::io_req_t io_req,
	output fpga_io_pkg::io_data_t io_read_data,
	output fpga_io_pkg::red_led_t red_led,
	output fpga_io_pkg::green_led_t green_led,
	output fpga_io_pkg::hex_digits_t digits,
	output fpga_io_pkg::blank_mask_t blank,
	output logic tx_start,
	output fpga_io_pkg::uart_byte_t tx_byte,
	input logic tx_busy
);

	// Display register layout, blank mask above the digits
	typedef struct packed {
		fpga_io_pkg::blank_mask_t blank;
		fpga_io_pkg::hex_digits_t digits;
	} display_reg_t;

	display_reg_t display_reg;

	// Address decode
	logic sel_red;
	logic sel_green;
	logic sel_hex;
	logic sel_uart;

	assign sel_red = io_req.address == fpga_io_pkg::IO_RED_LED;
	assign sel_green = io_req.address == fpga_io_pkg::IO_GREEN_LED;
	assign sel_hex = io_req.address == fpga_io_pkg::IO_HEX_DISPLAY;
	assign sel_uart = io_req.address == fpga_io_pkg::IO_UART;

	// LED and display registers
	// Upper write bits beyond each register are dropped
	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			red_led <= '0;
			green_led <= '0;
			display_reg <= '0;
		end else if (io_req.write_en) begin
			if (sel_red)
				red_led <= io_req.write_data[17:0];

			if (sel_green)
				green_led <= io_req.write_data[8:0];

			if (sel_hex)
				display_reg <= io_req.write_data[19:0];
		end
	end

	assign digits = display_reg.digits;
	assign blank = display_reg.blank;

	// Transmit request goes out with the write itself
	// Writes while busy are lost, software polls status first
	assign tx_start = io_req.write_en && sel_uart && !tx_busy;
	assign tx_byte = io_req.write_data[7:0];

	// Registered read reply, held until the next read
	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			io_read_data <= '0;
		end else if (io_req.read_en) begin
			io_read_data <= '0;
			if (sel_red)
				io_read_data <= fpga_io_pkg::io_data_t'(red_led);
			else if (sel_green)
				io_read_data <= fpga_io_pkg::io_data_t'(green_led);
			else if (sel_hex)
				io_read_data <= fpga_io_pkg::io_data_t'(display_reg);
			else if (sel_uart)
				// Busy sampled at the read edge
				io_read_data[fpga_io_pkg::UART_STATUS_BUSY_BIT] <= tx_busy;
		end
	end

	// Port protocol, one strobe per cycle
	assert property (@(posedge clk50) disable iff (!rst_n)
		!(io_req.write_en && io_req.read_en))
		else $error("io_regs: write and read strobes high together");

	// Start only from idle, transmitter must go busy on the next edge
	assert property (@(posedge clk50) disable iff (!rst_n)
		tx_start |-> !tx_busy ##1 tx_busy)
		else $error("io_regs: tx_start not followed by busy transmitter");

endmodule

`default_nettype wire

// File: verilog/hex_display.sv
// Seven-segment decoder for the four board displays; combinational from the display register
`timescale 1ns/1ps
`default_nettype none

module hex_display (
	input fpga_io_pkg::hex_digits_t digits,
	input fpga_io_pkg::blank_mask_t blank,
	output fpga_io_pkg::seg_t hex0,
	output fpga_io_pkg::seg_t hex1,
	output fpga_io_pkg::seg_t hex2,
	output fpga_io_pkg::seg_t hex3
);

	// Glyphs 0..F, segments g..a, zero lights a segment
	localparam fpga_io_pkg::seg_t GLYPHS [16] = '{
		7'b100_0000,	// 0
		7'b111_1001,	// 1
		7'b010_0100,	// 2
		7'b011_0000,	// 3
		7'b001_1001,	// 4
		7'b001_0010,	// 5
		7'b000_0010,	// 6
		7'b111_1000,	// 7
		7'b000_0000,	// 8
		7'b001_0000,	// 9
		7'b000_1000,	// A
		7'b000_0011,	// b
		7'b100_0110,	// C
		7'b010_0001,	// d
		7'b000_0110,	// E
		7'b000_1110	// F
	};

	fpga_io_pkg::seg_t lane_seg [4];

	// One lane per display, all sharing the table
	for (genvar lane = 0; lane < 4; lane++) begin : g_lane
		// Blanked digit shows nothing
		assign lane_seg[lane] = blank[lane] ? '1 : GLYPHS[digits[lane * 4 +: 4]];
	end

	assign hex0 = lane_seg[0];
	assign hex1 = lane_seg[1];
	assign hex2 = lane_seg[2];
	assign hex3 = lane_seg[3];

endmodule

`default_nettype wire

// File: verilog/uart_transmit.sv
// Serial transmitter, 8N1, one frame per start pulse; busy stays high for the whole frame
`timescale 1ns/1ps
`default_nettype none

module uart_transmit #(
	parameter int CLOCKS_PER_BIT = 16
) (
	input logic clk50,
	input logic rst_n,
	input logic tx_start,
	input fpga_io_pkg::uart_byte_t tx_byte,
	output logic tx_busy,
	output logic uart_tx
);

	localparam int TIMER_WIDTH = $clog2(CLOCKS_PER_BIT);

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

	tx_state_t state;
	logic [TIMER_WIDTH-1:0] bit_timer;
	logic [2:0] bit_index;
	fpga_io_pkg::uart_byte_t shift_reg;
	logic bit_done;
	logic next_data_bit;

	// Last clock of the current bit period
	assign bit_done = bit_timer == '0;

	// A data bit starts after start bit or after any data bit but the 8th
	assign next_data_bit = bit_done && (state == TX_START ||
		(state == TX_DATA && bit_index != 3'd7));

	assign tx_busy = state != TX_IDLE;

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			state <= TX_IDLE;
			bit_timer <= '0;
			bit_index <= '0;
			uart_tx <= 1'b1;
		end else begin
			if (state == TX_IDLE) begin
				if (tx_start) begin
					// Start bit on the line from this edge
					state <= TX_START;
					bit_timer <= TIMER_WIDTH'(CLOCKS_PER_BIT - 1);
					bit_index <= '0;
					uart_tx <= 1'b0;
				end
			end else if (!bit_done) begin
				bit_timer <= bit_timer - 1'b1;
			end else begin
				bit_timer <= TIMER_WIDTH'(CLOCKS_PER_BIT - 1);
				case (state)
					TX_START: begin
						state <= TX_DATA;
						uart_tx <= shift_reg[0];
					end

					TX_DATA: begin
						if (bit_index == 3'd7) begin
							state <= TX_STOP;
							uart_tx <= 1'b1;
						end else begin
							bit_index <= bit_index + 1'b1;
							uart_tx <= shift_reg[0];
						end
					end

					// Stop bit done, line already high
					default: state <= TX_IDLE;
				endcase
			end
		end
	end

	// Payload shifter, LSB first
	always_ff @(posedge clk50) begin
		if (state == TX_IDLE && tx_start)
			shift_reg <= tx_byte;
		else if (next_data_bit)
			shift_reg <= shift_reg >> 1;
	end

	// Line idles high between frames
	assert property (@(posedge clk50) disable iff (!rst_n)
		state == TX_IDLE |-> uart_tx)
		else $error("uart_transmit: line low while idle");

	// Register block must hold off while a frame is in flight
	assert property (@(posedge clk50) disable iff (!rst_n)
		tx_start |-> state == TX_IDLE)
		else $error("uart_transmit: start request during a frame");

endmodule

`default_nettype wire

// File: verilog/fpga_io_top.sv
// Board I/O top level; wires the register block to the LED pins, displays and serial line
`timescale 1ns/1ps
`default_nettype none

module fpga_io_top (
	input logic clk50,
	input logic rst_n,

	// Processor I/O port
	input fpga_io_pkg::io_req_t io_req,
	output fpga_io_pkg::io_data_t io_read_data,

	// Board pins
	output fpga_io_pkg::red_led_t red_led,
	output fpga_io_pkg::green_led_t green_led,
	output fpga_io_pkg::seg_t hex0,
	output fpga_io_pkg::seg_t hex1,
	output fpga_io_pkg::seg_t hex2,
	output fpga_io_pkg::seg_t hex3,
	output logic uart_tx
);

	// Display register fields
	fpga_io_pkg::hex_digits_t digits;
	fpga_io_pkg::blank_mask_t blank;

	// Transmit handshake
	logic tx_start;
	logic tx_busy;
	fpga_io_pkg::uart_byte_t tx_byte;

	io_regs io_regs (
		.clk50(clk50),
		.rst_n(rst_n),
		.io_req(io_req),
		.io_read_data(io_read_data),
		.red_led(red_led),
		.green_led(green_led),
		.digits(digits),
		.blank(blank),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx_busy(tx_busy)
	);

	hex_display hex_display (
		.digits(digits),
		.blank(blank),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3)
	);

	uart_transmit #(
		.CLOCKS_PER_BIT(fpga_io_pkg::UART_CLOCKS_PER_BIT)
	) uart_transmit (
		.clk50(clk50),
		.rst_n(rst_n),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx_busy(tx_busy),
		.uart_tx(uart_tx)
	);

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
// Testbench clock and reset source; 8 ns clk50 with rst_n held low for the first 8 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk50,
	output logic rst_n
);

	// 125 MHz sim clock, 4 ns per half period
	initial begin
		clk50 = 1'b0;
		forever #4 clk50 = ~clk50;
	end

	// Synchronous reset, released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk50);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: sim/io_checker.sv
// Testbench monitor; models the register map, decodes uart_tx and counts every mismatch
`timescale 1ns/1ps
`default_nettype none

module io_checker (
	input logic clk50,
	input logic rst_n,
	input fpga_io_pkg::io_req_t io_req,
	input logic expected_valid,
	input fpga_io_pkg::io_data_t expected_read,
	input fpga_io_pkg::io_data_t io_read_data,
	input fpga_io_pkg::red_led_t red_led,
	input fpga_io_pkg::green_led_t green_led,
	input fpga_io_pkg::seg_t hex0,
	input fpga_io_pkg::seg_t hex1,
	input fpga_io_pkg::seg_t hex2,
	input fpga_io_pkg::seg_t hex3,
	input logic uart_tx,
	output int mismatch_count = 0,
	output int frame_error_count = 0,
	output int frames_missing = 0
);

	// Reference model state
	fpga_io_pkg::red_led_t red_exp;
	fpga_io_pkg::green_led_t green_exp;
	logic [19:0] disp_exp;
	fpga_io_pkg::io_data_t read_exp;
	fpga_io_pkg::io_data_t table_exp;
	logic table_pending;
	// Clocks left in the frame, zero means idle
	int busy_cnt;
	// Bytes accepted but not yet seen on the line
	logic [7:0] sent_bytes [$];
	logic [7:0] rx_byte;
	logic [7:0] sent_byte;

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name,
			expected, actual);
		mismatch_count++;
	endtask

	// Lit segments by letter, a..g, active low on the pins
	function automatic fpga_io_pkg::seg_t glyph_for(input logic [3:0] digit);
		string lit;
		fpga_io_pkg::seg_t seg;
		case (digit)
			4'h0: lit = "abcdef";
			4'h1: lit = "bc";
			4'h2: lit = "abdeg";
			4'h3: lit = "abcdg";
			4'h4: lit = "bcfg";
			4'h5: lit = "acdfg";
			4'h6: lit = "acdefg";
			4'h7: lit = "abc";
			4'h8: lit = "abcdefg";
			4'h9: lit = "abcdfg";
			4'hA: lit = "abcefg";
			4'hB: lit = "cdefg";
			4'hC: lit = "adef";
			4'hD: lit = "bcdeg";
			4'hE: lit = "adefg";
			default: lit = "aefg";
		endcase
		seg = '1;
		for (int i = 0; i < lit.len(); i++)
			seg[lit[i] - "a"] = 1'b0;
		return seg;
	endfunction

	// Blanked lanes go fully dark
	function automatic fpga_io_pkg::seg_t lane_expected(input int lane);
		if (disp_exp[16 + lane])
			return '1;
		return glyph_for(disp_exp[lane * 4 +: 4]);
	endfunction

	// Model advances on the same edge as the DUT
	always @(posedge clk50) begin
		if (!rst_n) begin
			red_exp <= '0;
			green_exp <= '0;
			disp_exp <= '0;
			read_exp <= '0;
			table_pending <= 1'b0;
			busy_cnt <= 0;
		end else begin
			table_pending <= io_req.read_en && expected_valid;
			table_exp <= expected_read;
			if (busy_cnt != 0)
				busy_cnt <= busy_cnt - 1;
			if (io_req.write_en) begin
				case (io_req.address)
					fpga_io_pkg::IO_RED_LED: red_exp <= io_req.write_data[17:0];
					fpga_io_pkg::IO_GREEN_LED: green_exp <= io_req.write_data[8:0];
					fpga_io_pkg::IO_HEX_DISPLAY: disp_exp <= io_req.write_data[19:0];
					fpga_io_pkg::IO_UART: begin
						// Accepted only when idle
						if (busy_cnt == 0) begin
							busy_cnt <= 10 * fpga_io_pkg::UART_CLOCKS_PER_BIT;
							sent_bytes.push_back(io_req.write_data[7:0]);
						end
					end
					default: ;
				endcase
			end
			if (io_req.read_en) begin
				case (io_req.address)
					fpga_io_pkg::IO_RED_LED: read_exp <= {14'h0, red_exp};
					fpga_io_pkg::IO_GREEN_LED: read_exp <= {23'h0, green_exp};
					fpga_io_pkg::IO_HEX_DISPLAY: read_exp <= {12'h0, disp_exp};
					fpga_io_pkg::IO_UART: read_exp <= {31'h0, busy_cnt != 0};
					default: read_exp <= '0;
				endcase
			end
		end
	end

	// Outputs settled by the falling edge
	always @(negedge clk50) begin
		frames_missing = sent_bytes.size();
		if (rst_n) begin
			if (red_led !== red_exp)
				report_mismatch("red_led", red_exp, red_led);
			if (green_led !== green_exp)
				report_mismatch("green_led", green_exp, green_led);
			if (hex0 !== lane_expected(0))
				report_mismatch("hex0", lane_expected(0), hex0);
			if (hex1 !== lane_expected(1))
				report_mismatch("hex1", lane_expected(1), hex1);
			if (hex2 !== lane_expected(2))
				report_mismatch("hex2", lane_expected(2), hex2);
			if (hex3 !== lane_expected(3))
				report_mismatch("hex3", lane_expected(3), hex3);
			if (io_read_data !== read_exp)
				report_mismatch("io_read_data", read_exp, io_read_data);
			// Stimulus table's own expectation
			if (table_pending && io_read_data !== table_exp)
				report_mismatch("io_read_data", table_exp, io_read_data);
			if (busy_cnt == 0 && uart_tx !== 1'b1)
				report_mismatch("uart_tx", 1'b1, uart_tx);
		end
	end

	// Serial decoder, samples mid-bit from the start edge
	always begin
		@(negedge uart_tx);
		if (rst_n) begin
			repeat (fpga_io_pkg::UART_CLOCKS_PER_BIT / 2) @(negedge clk50);
			if (uart_tx !== 1'b0) begin
				$display("Frame error at %0t: start bit did not stay low", $time);
				frame_error_count++;
			end
			for (int i = 0; i < 8; i++) begin
				repeat (fpga_io_pkg::UART_CLOCKS_PER_BIT) @(negedge clk50);
				rx_byte[i] = uart_tx;
			end
			repeat (fpga_io_pkg::UART_CLOCKS_PER_BIT) @(negedge clk50);
			if (uart_tx !== 1'b1) begin
				$display("Frame error at %0t: stop bit was not high", $time);
				frame_error_count++;
			end
			if (sent_bytes.size() == 0) begin
				$display("Frame error at %0t: frame with byte %h was never requested",
					$time, rx_byte);
				frame_error_count++;
			end else begin
				sent_byte = sent_bytes.pop_front();
				if (rx_byte !== sent_byte)
					report_mismatch("uart_tx byte", sent_byte, rx_byte);
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_fpga_io_top.sv
// Testbench top for the board I/O block that plays a stimulus table against the I/O port
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_io_top;

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_POLL} op_t;

	// Table row with an expected value for reads
	typedef struct packed {
		op_t op;
		fpga_io_pkg::io_addr_t addr;
		fpga_io_pkg::io_data_t data;
		fpga_io_pkg::io_data_t expect_value;
	} entry_t;

	logic clk50;
	logic rst_n;
	fpga_io_pkg::io_req_t io_req;
	fpga_io_pkg::io_data_t io_read_data;
	fpga_io_pkg::red_led_t red_led;
	fpga_io_pkg::green_led_t green_led;
	fpga_io_pkg::seg_t hex0;
	fpga_io_pkg::seg_t hex1;
	fpga_io_pkg::seg_t hex2;
	fpga_io_pkg::seg_t hex3;
	logic uart_tx;
	logic expected_valid;
	fpga_io_pkg::io_data_t expected_read;
	int mismatch_count;
	int frame_error_count;
	int frames_missing;
	entry_t stim_table [$];
	logic table_built = 1'b0;
	int watchdog_cycles;

	tb_clock_gen clock_gen (.clk50(clk50), .rst_n(rst_n));

	fpga_io_top UUT (
		.clk50(clk50), .rst_n(rst_n), .io_req(io_req), .io_read_data(io_read_data),
		.red_led(red_led), .green_led(green_led),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .uart_tx(uart_tx)
	);

	io_checker monitor (
		.clk50(clk50), .rst_n(rst_n), .io_req(io_req),
		.expected_valid(expected_valid), .expected_read(expected_read),
		.io_read_data(io_read_data), .red_led(red_led), .green_led(green_led),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .uart_tx(uart_tx),
		.mismatch_count(mismatch_count), .frame_error_count(frame_error_count),
		.frames_missing(frames_missing)
	);

	task automatic add_entry(input op_t op, input fpga_io_pkg::io_addr_t addr,
		input fpga_io_pkg::io_data_t data, input fpga_io_pkg::io_data_t expect_value);
		entry_t e;
		e.op = op;
		e.addr = addr;
		e.data = data;
		e.expect_value = expect_value;
		stim_table.push_back(e);
	endtask

	task automatic build_table();
		logic [3:0] n;
		fpga_io_pkg::io_data_t v;
		// Reset values
		add_entry(OP_READ, fpga_io_pkg::IO_RED_LED, 0, 32'h0);
		add_entry(OP_READ, fpga_io_pkg::IO_GREEN_LED, 0, 32'h0);
		add_entry(OP_READ, fpga_io_pkg::IO_HEX_DISPLAY, 0, 32'h0);
		add_entry(OP_READ, fpga_io_pkg::IO_UART, 0, 32'h0);
		// LED widths of 18 red and 9 green bits
		add_entry(OP_WRITE, fpga_io_pkg::IO_RED_LED, 32'hFFFF_FFFF, 0);
		add_entry(OP_READ, fpga_io_pkg::IO_RED_LED, 0, 32'h0003_FFFF);
		add_entry(OP_WRITE, fpga_io_pkg::IO_RED_LED, 32'hA5A5_5A5A, 0);
		add_entry(OP_READ, fpga_io_pkg::IO_RED_LED, 0, 32'h0001_5A5A);
		add_entry(OP_WRITE, fpga_io_pkg::IO_GREEN_LED, 32'hFFFF_FFFF, 0);
		add_entry(OP_READ, fpga_io_pkg::IO_GREEN_LED, 0, 32'h0000_01FF);
		add_entry(OP_WRITE, fpga_io_pkg::IO_GREEN_LED, 32'h1234_5AA5, 0);
		add_entry(OP_READ, fpga_io_pkg::IO_GREEN_LED, 0, 32'h0000_00A5);
		// Rotating digits so every value visits every display
		for (int d = 0; d < 16; d++) begin
			n = d[3:0];
			v = {16'h0000, n + 4'd3, n + 4'd2, n + 4'd1, n};
			add_entry(OP_WRITE, fpga_io_pkg::IO_HEX_DISPLAY, v, 0);
			add_entry(OP_READ, fpga_io_pkg::IO_HEX_DISPLAY, 0, v);
		end
		add_entry(OP_WRITE, fpga_io_pkg::IO_HEX_DISPLAY, 32'hFFF0_1234, 0);
		add_entry(OP_READ, fpga_io_pkg::IO_HEX_DISPLAY, 0, 32'h0000_1234);
		// Blank masks
		add_entry(OP_WRITE, fpga_io_pkg::IO_HEX_DISPLAY, 32'h0005_CAFE, 0);
		add_entry(OP_READ, fpga_io_pkg::IO_HEX_DISPLAY, 0, 32'h0005_CAFE);
		add_entry(OP_WRITE, fpga_io_pkg::IO_HEX_DISPLAY, 32'h000A_BEEF, 0);
		add_entry(OP_WRITE, fpga_io_pkg::IO_HEX_DISPLAY, 32'h000F_0000, 0);
		add_entry(OP_WRITE, fpga_io_pkg::IO_HEX_DISPLAY, 32'h0000_0000, 0);
		// Unmapped space reads zero and swallows writes
		add_entry(OP_WRITE, 32'h0000_0010, 32'hFFFF_FFFF, 0);
		add_entry(OP_WRITE, 32'h0000_001C, 32'hFFFF_FFFF, 0);
		add_entry(OP_WRITE, 32'hFFFF_FFFC, 32'h0000_00FF, 0);
		add_entry(OP_READ, 32'h0000_0010, 0, 32'h0);
		add_entry(OP_READ, 32'h0000_0003, 0, 32'h0);
		add_entry(OP_READ, 32'hFFFF_FFF0, 0, 32'h0);
		add_entry(OP_READ, fpga_io_pkg::IO_RED_LED, 0, 32'h0001_5A5A);
		add_entry(OP_READ, fpga_io_pkg::IO_HEX_DISPLAY, 0, 32'h0);
		// Single frame with only the low byte going out
		add_entry(OP_WRITE, fpga_io_pkg::IO_UART, 32'h1234_56A5, 0);
		add_entry(OP_READ, fpga_io_pkg::IO_UART, 0, 32'h1);
		add_entry(OP_POLL, fpga_io_pkg::IO_UART, 0, 0);
		add_entry(OP_READ, fpga_io_pkg::IO_UART, 0, 32'h0);
		// Second byte lands during busy and is lost
		add_entry(OP_WRITE, fpga_io_pkg::IO_UART, 32'h0000_003C, 0);
		add_entry(OP_WRITE, fpga_io_pkg::IO_UART, 32'h0000_00C3, 0);
		add_entry(OP_READ, fpga_io_pkg::IO_UART, 0, 32'h1);
		add_entry(OP_POLL, fpga_io_pkg::IO_UART, 0, 0);
		add_entry(OP_READ, fpga_io_pkg::IO_UART, 0, 32'h0);
		add_entry(OP_WRITE, fpga_io_pkg::IO_UART, 32'h0000_0081, 0);
		add_entry(OP_POLL, fpga_io_pkg::IO_UART, 0, 0);
	endtask

	function automatic int count_uart_writes();
		int total;
		total = 0;
		foreach (stim_table[i])
			if (stim_table[i].op == OP_WRITE && stim_table[i].addr == fpga_io_pkg::IO_UART)
				total++;
		return total;
	endfunction

	// One strobe cycle then one idle cycle
	// Reply sampled in the middle of the idle cycle
	task automatic drive_strobe(input logic write_en, input logic read_en,
		input fpga_io_pkg::io_addr_t addr, input fpga_io_pkg::io_data_t data,
		input logic check, input fpga_io_pkg::io_data_t expect_value,
		output fpga_io_pkg::io_data_t read_back);
		fpga_io_pkg::io_req_t req;
		req = '0;
		req.write_en = write_en;
		req.read_en = read_en;
		req.address = addr;
		req.write_data = data;
		io_req <= req;
		expected_valid <= check;
		expected_read <= expect_value;
		@(posedge clk50);
		io_req <= '0;
		expected_valid <= 1'b0;
		@(negedge clk50);
		read_back = io_read_data;
		@(posedge clk50);
	endtask

	task automatic apply_entry(input entry_t e);
		fpga_io_pkg::io_data_t status;
		case (e.op)
			OP_WRITE: drive_strobe(1'b1, 1'b0, e.addr, e.data, 1'b0, 0, status);
			OP_READ: drive_strobe(1'b0, 1'b1, e.addr, 0, 1'b1, e.expect_value, status);
			default: begin
				// Read status until the busy bit clears
				status = 32'h1;
				while (status[fpga_io_pkg::UART_STATUS_BUSY_BIT])
					drive_strobe(1'b0, 1'b1, fpga_io_pkg::IO_UART, 0, 1'b0, 0, status);
			end
		endcase
	endtask

	// Watchdog sized from the table and the number of frames
	initial begin
		wait (table_built);
		watchdog_cycles = 8 + stim_table.size() * 4 +
			count_uart_writes() * 12 * 10 * fpga_io_pkg::UART_CLOCKS_PER_BIT;
		repeat (watchdog_cycles) @(posedge clk50);
		$display("Timeout: stimulus still running after %0d clock cycles", watchdog_cycles);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		io_req = '0;
		expected_valid = 1'b0;
		expected_read = '0;
		build_table();
		table_built = 1'b1;
		wait (rst_n === 1'b1);
		@(posedge clk50);
		foreach (stim_table[i])
			apply_entry(stim_table[i]);
		repeat (4) @(posedge clk50);
		$display("Errors: %0d mismatches, %0d frame errors, %0d frames never sent",
			mismatch_count, frame_error_count, frames_missing);
		if (mismatch_count == 0 && frame_error_count == 0 && frames_missing == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
verilog/fpga_io_pkg.sv
verilog/io_regs.sv
verilog/hex_display.sv
verilog/uart_transmit.sv
verilog/fpga_io_top.sv
sim/tb_clock_gen.sv
sim/io_checker.sv
sim/tb_fpga_io_top.sv
